//--- common/tcp_pkg.sv
// Shared sizes, flag positions, connection states and response opcodes of the TCP controller
package tcp_pkg;

	// ----------------------------------------
	// Sizes

	// Transmit buffers behind the arbiter
	localparam int BUF_NUM = 4;
	localparam int SEQ_W = 32;
	// Lengths and ports share this width
	localparam int LEN_W = 16;
	// Header length in 32-bit words without options
	localparam logic [3:0] HDR_WORDS = 4'd5;
	// Initial send sequence number
	localparam logic [SEQ_W-1:0] ISS = '0;

	// ----------------------------------------
	// Bit positions in the 6-bit flag field

	localparam int FLG_FIN = 0;
	localparam int FLG_SYN = 1;
	localparam int FLG_RST = 2;
	localparam int FLG_PSH = 3;
	localparam int FLG_ACK = 4;

	// ----------------------------------------
	// Server side connection states
	typedef enum logic [2:0] {
		LISTEN,
		SYN_RCVD,
		ESTABLISHED,
		CLOSE_WAIT,
		LAST_ACK,
		CLOSED
	} conn_state_t;

	// Segment kinds the controller can send
	typedef enum logic [2:0] {
		RESP_SYNACK,
		RESP_ACK,
		RESP_FINACK,
		RESP_RST,
		RESP_DATA
	} resp_kind_t;

endpackage

//--- source/tcp_rx_latch.sv
// Single-entry holding register for received segment headers, with peer port filtering
module tcp_rx_latch (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      seg_valid_i,
	input  logic [tcp_pkg::LEN_W-1:0] seg_src_port_i,
	input  logic [5:0]                seg_flags_i,
	input  logic [tcp_pkg::SEQ_W-1:0] seg_seq_i,
	input  logic [tcp_pkg::LEN_W-1:0] seg_len_i,
	input  logic [tcp_pkg::LEN_W-1:0] peer_port_i,
	input  logic                      connected_i,
	input  logic                      consume_i,
	output logic                      seg_rd_o,
	output logic                      seg_full_o,
	output logic [5:0]                lat_flags_o,
	output logic [tcp_pkg::SEQ_W-1:0] lat_seq_o,
	output logic [tcp_pkg::LEN_W-1:0] lat_len_o,
	output logic [tcp_pkg::LEN_W-1:0] lat_src_port_o
);

	logic full;
	logic take;
	logic foreign;
	logic keep;

	// Read strobe is up whenever the entry is free
	assign seg_rd_o = !full;
	assign take = seg_valid_i && !full;

	// Once connected only the peer port is accepted
	assign foreign = connected_i && (seg_src_port_i != peer_port_i);
	assign keep = take && !foreign;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			full <= 1'b0;
		else if (consume_i)
			full <= 1'b0;
		else if (keep)
			full <= 1'b1;
	end

	// Header fields
	always_ff @(posedge clk)
	begin
		if (keep)
		begin
			lat_flags_o <= seg_flags_i;
			lat_seq_o <= seg_seq_i;
			lat_len_o <= seg_len_i;
			lat_src_port_o <= seg_src_port_i;
		end
	end

	assign seg_full_o = full;

	// FSM may only take a segment that is actually held
	a_consume_full: assert property (@(posedge clk) disable iff (!rst_n)
		consume_i |-> full);

endmodule

//--- tcp_ctrl/tcp_conn_fsm.sv
// Server side TCP connection FSM that consumes latched segments and picks the reply to send
module tcp_conn_fsm (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      seg_full_i,
	input  logic [5:0]                lat_flags_i,
	input  logic [tcp_pkg::LEN_W-1:0] lat_len_i,
	input  logic                      tx_busy_i,
	input  logic                      grant_valid_i,
	output logic                      consume_o,
	output logic                      resp_go_o,
	output tcp_pkg::resp_kind_t       resp_kind_o,
	output logic                      peer_port_we_o,
	output logic                      connected_o,
	output logic                      state_listen_o,
	output logic                      state_estab_o
);

	tcp_pkg::conn_state_t state;
	logic send_ok;
	logic syn;
	logic ack;
	logic fin;
	logic rst;

	assign syn = lat_flags_i[tcp_pkg::FLG_SYN];
	assign ack = lat_flags_i[tcp_pkg::FLG_ACK];
	assign fin = lat_flags_i[tcp_pkg::FLG_FIN];
	assign rst = lat_flags_i[tcp_pkg::FLG_RST];

	// Transmitter free and no request issued in this cycle
	assign send_ok = !tx_busy_i && !resp_go_o;
	assign consume_o = seg_full_i && send_ok;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= tcp_pkg::LISTEN;
			resp_go_o <= 1'b0;
			resp_kind_o <= tcp_pkg::RESP_ACK;
			peer_port_we_o <= 1'b0;
		end
		else
		begin
			resp_go_o <= 1'b0;
			peer_port_we_o <= 1'b0;
			if (consume_o)
			begin
				// RST aborts from any state with no reply
				if (rst)
					state <= tcp_pkg::LISTEN;
				else
				begin
					case (state)
						tcp_pkg::LISTEN:
							if (syn && !ack)
							begin
								state <= tcp_pkg::SYN_RCVD;
								resp_go_o <= 1'b1;
								resp_kind_o <= tcp_pkg::RESP_SYNACK;
								peer_port_we_o <= 1'b1;
							end
						tcp_pkg::SYN_RCVD:
							if (syn)
								state <= tcp_pkg::CLOSED;
							else if (ack)
								state <= tcp_pkg::ESTABLISHED;
						tcp_pkg::ESTABLISHED:
							if (syn)
							begin
								state <= tcp_pkg::LISTEN;
								resp_go_o <= 1'b1;
								resp_kind_o <= tcp_pkg::RESP_RST;
							end
							else if (fin)
							begin
								state <= tcp_pkg::CLOSE_WAIT;
								resp_go_o <= 1'b1;
								resp_kind_o <= tcp_pkg::RESP_ACK;
							end
							else if (ack && (lat_len_i != '0))
							begin
								resp_go_o <= 1'b1;
								resp_kind_o <= tcp_pkg::RESP_ACK;
							end
						tcp_pkg::LAST_ACK:
							if (ack)
								state <= tcp_pkg::CLOSED;
						default:
							state <= state;
					endcase
				end
			end
			else
			begin
				// ----------------------------------------
				// Actions without a received segment
				case (state)
					tcp_pkg::CLOSE_WAIT:
						if (send_ok)
						begin
							state <= tcp_pkg::LAST_ACK;
							resp_go_o <= 1'b1;
							resp_kind_o <= tcp_pkg::RESP_FINACK;
						end
					tcp_pkg::CLOSED:
						state <= tcp_pkg::LISTEN;
					tcp_pkg::ESTABLISHED:
						if (send_ok && !seg_full_i && grant_valid_i)
						begin
							resp_go_o <= 1'b1;
							resp_kind_o <= tcp_pkg::RESP_DATA;
						end
					default:
						state <= state;
				endcase
			end
		end
	end

	assign connected_o = (state == tcp_pkg::ESTABLISHED);
	assign state_listen_o = (state == tcp_pkg::LISTEN);
	assign state_estab_o = (state == tcp_pkg::ESTABLISHED);

	// Header builder must be idle whenever a new reply starts
	a_go_idle: assert property (@(posedge clk) disable iff (!rst_n)
		resp_go_o |-> !tx_busy_i);

endmodule

//--- tcp_ctrl/tcp_tx_header.sv
// Outgoing header builder with send sequence tracking and the req/ack transmit handshake
module tcp_tx_header (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      resp_go_i,
	input  tcp_pkg::resp_kind_t       resp_kind_i,
	input  logic                      peer_port_we_i,
	input  logic [tcp_pkg::SEQ_W-1:0] lat_seq_i,
	input  logic [tcp_pkg::LEN_W-1:0] lat_len_i,
	input  logic                      lat_fin_i,
	input  logic [tcp_pkg::LEN_W-1:0] lat_src_port_i,
	input  logic [tcp_pkg::LEN_W-1:0] buf_len_i,
	input  logic                      tx_ack_i,
	output logic                      tx_req_o,
	output logic                      tx_busy_o,
	output logic [5:0]                tx_flags_o,
	output logic [tcp_pkg::SEQ_W-1:0] tx_seq_o,
	output logic [tcp_pkg::SEQ_W-1:0] tx_ack_num_o,
	output logic [tcp_pkg::LEN_W-1:0] tx_len_o,
	output logic [3:0]                tx_hdr_len_o,
	output logic [tcp_pkg::LEN_W-1:0] tx_dst_port_o,
	output logic [tcp_pkg::LEN_W-1:0] peer_port_o,
	output logic                      buf_done_o
);

	tcp_pkg::resp_kind_t kind_r;
	logic busy;
	logic done;
	logic [tcp_pkg::LEN_W-1:0] peer_port;
	logic [tcp_pkg::SEQ_W-1:0] snd_nxt;
	logic [tcp_pkg::SEQ_W-1:0] seg_end;
	logic [5:0] nxt_flags;
	logic [tcp_pkg::SEQ_W-1:0] nxt_seq;
	logic [tcp_pkg::SEQ_W-1:0] nxt_ack;
	logic [tcp_pkg::LEN_W-1:0] nxt_len;

	// First sequence number after the received segment
	assign seg_end = lat_seq_i + {{(tcp_pkg::SEQ_W - tcp_pkg::LEN_W){1'b0}}, lat_len_i};

	// ----------------------------------------
	// Field selection per reply kind
	always_comb
	begin
		nxt_flags = '0;
		nxt_seq = snd_nxt;
		nxt_ack = tx_ack_num_o;
		nxt_len = '0;
		case (resp_kind_i)
			tcp_pkg::RESP_SYNACK:
			begin
				nxt_flags[tcp_pkg::FLG_SYN] = 1'b1;
				nxt_flags[tcp_pkg::FLG_ACK] = 1'b1;
				nxt_seq = tcp_pkg::ISS;
				nxt_ack = lat_seq_i + 1;
			end
			tcp_pkg::RESP_ACK:
			begin
				nxt_flags[tcp_pkg::FLG_ACK] = 1'b1;
				// FIN occupies one sequence number
				nxt_ack = seg_end + {{(tcp_pkg::SEQ_W - 1){1'b0}}, lat_fin_i};
			end
			tcp_pkg::RESP_FINACK:
			begin
				nxt_flags[tcp_pkg::FLG_FIN] = 1'b1;
				nxt_flags[tcp_pkg::FLG_ACK] = 1'b1;
			end
			tcp_pkg::RESP_RST:
			begin
				nxt_flags[tcp_pkg::FLG_RST] = 1'b1;
				nxt_ack = seg_end;
			end
			tcp_pkg::RESP_DATA:
			begin
				nxt_flags[tcp_pkg::FLG_PSH] = 1'b1;
				nxt_flags[tcp_pkg::FLG_ACK] = 1'b1;
				nxt_len = buf_len_i;
			end
			default:
				nxt_len = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (resp_go_i)
		begin
			tx_flags_o <= nxt_flags;
			tx_seq_o <= nxt_seq;
			tx_ack_num_o <= nxt_ack;
			tx_len_o <= nxt_len;
		end
	end

	// Handshake ends once ack has dropped after req
	assign done = busy && !tx_req_o && !tx_ack_i;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			tx_req_o <= 1'b0;
			busy <= 1'b0;
			kind_r <= tcp_pkg::RESP_ACK;
			snd_nxt <= tcp_pkg::ISS;
			peer_port <= '0;
		end
		else
		begin
			if (resp_go_i)
			begin
				tx_req_o <= 1'b1;
				busy <= 1'b1;
				kind_r <= resp_kind_i;
				if (resp_kind_i == tcp_pkg::RESP_SYNACK)
					snd_nxt <= tcp_pkg::ISS + 1;
			end
			else if (tx_req_o && tx_ack_i)
				tx_req_o <= 1'b0;
			else if (done)
			begin
				busy <= 1'b0;
				// Payload is counted as sent only at completion
				if (kind_r == tcp_pkg::RESP_DATA)
					snd_nxt <= snd_nxt + {{(tcp_pkg::SEQ_W - tcp_pkg::LEN_W){1'b0}}, tx_len_o};
			end
			if (peer_port_we_i)
				peer_port <= lat_src_port_i;
		end
	end

	assign tx_busy_o = busy;
	assign buf_done_o = done && (kind_r == tcp_pkg::RESP_DATA);
	assign tx_hdr_len_o = tcp_pkg::HDR_WORDS;
	assign tx_dst_port_o = peer_port;
	assign peer_port_o = peer_port;

	// Transmitter sees a frozen header for the whole request
	a_hdr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		tx_req_o |=> (!tx_req_o || $stable({tx_flags_o, tx_seq_o, tx_ack_num_o,
			tx_len_o, tx_dst_port_o})));

endmodule

//--- source/tcp_buf_arbiter.sv
// Round-robin arbiter granting one ready transmit buffer to the transmitter until release
module tcp_buf_arbiter (
	input  logic                                      clk,
	input  logic                                      rst_n,
	input  logic [tcp_pkg::BUF_NUM-1:0]               buf_ready_i,
	input  logic                                      release_i,
	input  logic [tcp_pkg::BUF_NUM*tcp_pkg::LEN_W-1:0] buf_len_i,
	output logic [tcp_pkg::BUF_NUM-1:0]               buf_sel_o,
	output logic                                      grant_valid_o,
	output logic [tcp_pkg::LEN_W-1:0]                 grant_len_o
);

	typedef logic [$clog2(tcp_pkg::BUF_NUM)-1:0] idx_t;

	idx_t last_idx;
	idx_t grant_idx;
	idx_t next_idx;
	logic next_found;

	// Nearest ready buffer after the last one served
	always_comb
	begin
		int cand;
		next_idx = last_idx;
		next_found = 1'b0;
		// Scanned from far to near so the nearest one wins
		for (int i = tcp_pkg::BUF_NUM; i >= 1; i--)
		begin
			cand = (int'(last_idx) + i) % tcp_pkg::BUF_NUM;
			if (buf_ready_i[cand])
			begin
				next_idx = idx_t'(cand);
				next_found = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			grant_valid_o <= 1'b0;
			grant_idx <= '0;
			last_idx <= idx_t'(tcp_pkg::BUF_NUM - 1);
		end
		else if (grant_valid_o)
		begin
			if (release_i)
			begin
				grant_valid_o <= 1'b0;
				last_idx <= grant_idx;
			end
		end
		else if (next_found)
		begin
			grant_valid_o <= 1'b1;
			grant_idx <= next_idx;
		end
	end

	always_comb
	begin
		buf_sel_o = '0;
		if (grant_valid_o)
			buf_sel_o[grant_idx] = 1'b1;
	end

	assign grant_len_o = buf_len_i[grant_idx*tcp_pkg::LEN_W +: tcp_pkg::LEN_W];

	// Release only arrives while exactly one buffer is selected
	a_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		release_i |-> $onehot(buf_sel_o));

endmodule

//--- source/tcp_controller_top.sv
// Top level of the passive-open TCP controller connecting latch, FSM, header builder and arbiter
module tcp_controller_top (
	input  logic                                      clk,
	input  logic                                      rst_n,
	input  logic                                      seg_valid_i,
	input  logic [tcp_pkg::LEN_W-1:0]                 seg_src_port_i,
	input  logic [5:0]                                seg_flags_i,
	input  logic [tcp_pkg::SEQ_W-1:0]                 seg_seq_i,
	input  logic [tcp_pkg::LEN_W-1:0]                 seg_len_i,
	input  logic                                      tx_ack_i,
	input  logic [tcp_pkg::BUF_NUM-1:0]               buf_ready_i,
	input  logic [tcp_pkg::BUF_NUM*tcp_pkg::LEN_W-1:0] buf_len_i,
	output logic                                      seg_rd_o,
	output logic                                      tx_req_o,
	output logic [5:0]                                tx_flags_o,
	output logic [tcp_pkg::SEQ_W-1:0]                 tx_seq_o,
	output logic [tcp_pkg::SEQ_W-1:0]                 tx_ack_num_o,
	output logic [tcp_pkg::LEN_W-1:0]                 tx_len_o,
	output logic [3:0]                                tx_hdr_len_o,
	output logic [tcp_pkg::LEN_W-1:0]                 tx_dst_port_o,
	output logic [tcp_pkg::BUF_NUM-1:0]               buf_sel_o,
	output logic                                      buf_done_o,
	output logic                                      state_listen_o,
	output logic                                      state_estab_o
);

	// ----------------------------------------
	// Internal connections
	logic seg_full;
	logic consume;
	logic [5:0] lat_flags;
	logic [tcp_pkg::SEQ_W-1:0] lat_seq;
	logic [tcp_pkg::LEN_W-1:0] lat_len;
	logic [tcp_pkg::LEN_W-1:0] lat_src_port;
	logic [tcp_pkg::LEN_W-1:0] peer_port;
	logic connected;
	logic resp_go;
	tcp_pkg::resp_kind_t resp_kind;
	logic peer_port_we;
	logic tx_busy;
	logic grant_valid;
	logic [tcp_pkg::LEN_W-1:0] grant_len;

	tcp_rx_latch u_rx_latch (
		.clk            (clk),
		.rst_n          (rst_n),
		.seg_valid_i    (seg_valid_i),
		.seg_src_port_i (seg_src_port_i),
		.seg_flags_i    (seg_flags_i),
		.seg_seq_i      (seg_seq_i),
		.seg_len_i      (seg_len_i),
		.peer_port_i    (peer_port),
		.connected_i    (connected),
		.consume_i      (consume),
		.seg_rd_o       (seg_rd_o),
		.seg_full_o     (seg_full),
		.lat_flags_o    (lat_flags),
		.lat_seq_o      (lat_seq),
		.lat_len_o      (lat_len),
		.lat_src_port_o (lat_src_port)
	);

	tcp_conn_fsm u_conn_fsm (
		.clk            (clk),
		.rst_n          (rst_n),
		.seg_full_i     (seg_full),
		.lat_flags_i    (lat_flags),
		.lat_len_i      (lat_len),
		.tx_busy_i      (tx_busy),
		.grant_valid_i  (grant_valid),
		.consume_o      (consume),
		.resp_go_o      (resp_go),
		.resp_kind_o    (resp_kind),
		.peer_port_we_o (peer_port_we),
		.connected_o    (connected),
		.state_listen_o (state_listen_o),
		.state_estab_o  (state_estab_o)
	);

	tcp_tx_header u_tx_header (
		.clk            (clk),
		.rst_n          (rst_n),
		.resp_go_i      (resp_go),
		.resp_kind_i    (resp_kind),
		.peer_port_we_i (peer_port_we),
		.lat_seq_i      (lat_seq),
		.lat_len_i      (lat_len),
		.lat_fin_i      (lat_flags[tcp_pkg::FLG_FIN]),
		.lat_src_port_i (lat_src_port),
		.buf_len_i      (grant_len),
		.tx_ack_i       (tx_ack_i),
		.tx_req_o       (tx_req_o),
		.tx_busy_o      (tx_busy),
		.tx_flags_o     (tx_flags_o),
		.tx_seq_o       (tx_seq_o),
		.tx_ack_num_o   (tx_ack_num_o),
		.tx_len_o       (tx_len_o),
		.tx_hdr_len_o   (tx_hdr_len_o),
		.tx_dst_port_o  (tx_dst_port_o),
		.peer_port_o    (peer_port),
		.buf_done_o     (buf_done_o)
	);

	// Grant is released by the completion of a data request
	tcp_buf_arbiter u_buf_arbiter (
		.clk           (clk),
		.rst_n         (rst_n),
		.buf_ready_i   (buf_ready_i),
		.release_i     (buf_done_o),
		.buf_len_i     (buf_len_i),
		.buf_sel_o     (buf_sel_o),
		.grant_valid_o (grant_valid),
		.grant_len_o   (grant_len)
	);

endmodule

//--- bench/tcp_checker.sv
// Scoreboard that compares each transmit request and state probe with the queued expectations
module tcp_checker (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        tx_req_i,
	input  logic [5:0]                  tx_flags_i,
	input  logic [tcp_pkg::SEQ_W-1:0]   tx_seq_i,
	input  logic [tcp_pkg::SEQ_W-1:0]   tx_ack_num_i,
	input  logic [tcp_pkg::LEN_W-1:0]   tx_len_i,
	input  logic [3:0]                  tx_hdr_len_i,
	input  logic [tcp_pkg::LEN_W-1:0]   tx_dst_port_i,
	input  logic [tcp_pkg::BUF_NUM-1:0] buf_sel_i,
	input  logic                        buf_done_i,
	input  logic                        state_listen_i,
	input  logic                        state_estab_i,
	input  logic                        exp_push_i,
	input  logic [5:0]                  exp_flags_i,
	input  logic [tcp_pkg::SEQ_W-1:0]   exp_seq_i,
	input  logic [tcp_pkg::SEQ_W-1:0]   exp_ack_i,
	input  logic [tcp_pkg::LEN_W-1:0]   exp_len_i,
	input  logic [tcp_pkg::LEN_W-1:0]   exp_dst_i,
	input  logic [tcp_pkg::BUF_NUM-1:0] exp_sel_i,
	input  logic                        st_chk_i,
	input  logic                        st_listen_i,
	input  logic                        st_estab_i,
	input  logic                        test_end_i,
	input  logic [3:0]                  test_id_i,
	output int                          chk_cnt_o,
	output int                          err_cnt_o
);
	timeunit 1ns;
	timeprecision 100ps;

	// Five words, a header without options
	localparam logic [3:0] HDR_LEN = 4'd5;

	// Flags, seq, ack, len, dst port and buffer select of one request
	logic [105:0] exp_q [$];
	logic req_d;
	logic pend_done;
	int chk_cnt = 0;
	int err_cnt = 0;
	int test_chk = 0;
	int test_err = 0;

	assign chk_cnt_o = chk_cnt;
	assign err_cnt_o = err_cnt;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		err_cnt++;
		test_err++;
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		chk_cnt++;
		test_chk++;
		if (got !== exp)
		begin
			$display("ERR %s got %0h exp %0h", name, got, exp);
			err_cnt++;
			test_err++;
		end
	endtask

	task automatic check_request();
		logic [5:0] f;
		logic [31:0] s;
		logic [31:0] a;
		logic [15:0] l;
		logic [15:0] d;
		logic [3:0] b;
		if (pend_done)
			report_failure("data request ended without a buf_done_o pulse");
		if (exp_q.size() == 0)
			report_failure($sformatf("unexpected transmit request with flags %0h", tx_flags_i));
		else
		begin
			{f, s, a, l, d, b} = exp_q.pop_front();
			compare_value("tx_flags_o", {26'd0, tx_flags_i}, {26'd0, f});
			compare_value("tx_seq_o", tx_seq_i, s);
			compare_value("tx_ack_num_o", tx_ack_num_i, a);
			compare_value("tx_len_o", {16'd0, tx_len_i}, {16'd0, l});
			compare_value("tx_hdr_len_o", {28'd0, tx_hdr_len_i}, {28'd0, HDR_LEN});
			compare_value("tx_dst_port_o", {16'd0, tx_dst_port_i}, {16'd0, d});
			compare_value("buf_sel_o", {28'd0, buf_sel_i}, {28'd0, b});
			pend_done = f[tcp_pkg::FLG_PSH];
		end
	endtask

	task automatic close_test();
		if (exp_q.size() != 0)
		begin
			report_failure($sformatf("%0d expected requests never appeared", exp_q.size()));
			exp_q.delete();
		end
		if (pend_done)
			report_failure("last data request got no buf_done_o pulse");
		pend_done = 1'b0;
		$display("Test %0d finished: %0d checks, %0d errors", test_id_i, test_chk, test_err);
		test_chk = 0;
		test_err = 0;
	endtask

	// Sampled on the rising edge, one cycle after a request rises
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			req_d = 1'b0;
			pend_done = 1'b0;
		end
		else
		begin
			if (exp_push_i)
				exp_q.push_back({exp_flags_i, exp_seq_i, exp_ack_i, exp_len_i, exp_dst_i,
					exp_sel_i});
			if (tx_req_i && !req_d)
				check_request();
			req_d = tx_req_i;
			if (buf_done_i)
			begin
				if (!pend_done)
					report_failure("buf_done_o pulsed with no data request pending");
				pend_done = 1'b0;
			end
			if (st_chk_i)
			begin
				compare_value("state_listen_o", {31'd0, state_listen_i}, {31'd0, st_listen_i});
				compare_value("state_estab_o", {31'd0, state_estab_i}, {31'd0, st_estab_i});
			end
			if (test_end_i)
				close_test();
		end
	end

endmodule

//--- bench/tb_tcp.sv
// Testbench for the TCP controller with peer and transmitter models and seeded random stimulus
module tb_tcp;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_DATA = 6;
	localparam int N_ROUNDS = 3;
	// Peer segments plus transmit requests, 200 cycles for each
	localparam int CYCLE_LIMIT = 200 * (N_DATA + 4 * N_ROUNDS + 8);

	localparam logic [5:0] F_FIN = 6'b1 << tcp_pkg::FLG_FIN;
	localparam logic [5:0] F_SYN = 6'b1 << tcp_pkg::FLG_SYN;
	localparam logic [5:0] F_RST = 6'b1 << tcp_pkg::FLG_RST;
	localparam logic [5:0] F_PSH = 6'b1 << tcp_pkg::FLG_PSH;
	localparam logic [5:0] F_ACK = 6'b1 << tcp_pkg::FLG_ACK;

	logic clk;
	logic rst_n;
	logic seg_valid;
	logic [tcp_pkg::LEN_W-1:0] seg_src_port;
	logic [5:0] seg_flags;
	logic [tcp_pkg::SEQ_W-1:0] seg_seq;
	logic [tcp_pkg::LEN_W-1:0] seg_len;
	logic tx_ack;
	logic [tcp_pkg::BUF_NUM-1:0] buf_ready;
	logic [tcp_pkg::BUF_NUM*tcp_pkg::LEN_W-1:0] buf_len;
	logic seg_rd;
	logic tx_req;
	logic [5:0] tx_flags;
	logic [tcp_pkg::SEQ_W-1:0] tx_seq;
	logic [tcp_pkg::SEQ_W-1:0] tx_ack_num;
	logic [tcp_pkg::LEN_W-1:0] tx_len;
	logic [3:0] tx_hdr_len;
	logic [tcp_pkg::LEN_W-1:0] tx_dst_port;
	logic [tcp_pkg::BUF_NUM-1:0] buf_sel;
	logic buf_done;
	logic state_listen;
	logic state_estab;

	// Expectations and strobes towards the checker
	logic exp_push;
	logic [5:0] exp_flags;
	logic [tcp_pkg::SEQ_W-1:0] exp_seq;
	logic [tcp_pkg::SEQ_W-1:0] exp_ack;
	logic [tcp_pkg::LEN_W-1:0] exp_len;
	logic [tcp_pkg::LEN_W-1:0] exp_dst;
	logic [tcp_pkg::BUF_NUM-1:0] exp_sel;
	logic st_chk;
	logic st_listen;
	logic st_estab;
	logic test_end;
	logic [3:0] test_id;
	int chk_cnt;
	int err_cnt;

	// Model of the connection as the peer sees it
	int seed = 13562;
	int served = 0;
	int expected = 0;
	int cycles = 0;
	int last_buf;
	logic [tcp_pkg::LEN_W-1:0] peer_port;
	logic [tcp_pkg::SEQ_W-1:0] snd_nxt;
	logic [tcp_pkg::SEQ_W-1:0] last_ack;
	logic [tcp_pkg::LEN_W-1:0] blen [tcp_pkg::BUF_NUM];

	tcp_controller_top DUT (
		.clk            (clk),
		.rst_n          (rst_n),
		.seg_valid_i    (seg_valid),
		.seg_src_port_i (seg_src_port),
		.seg_flags_i    (seg_flags),
		.seg_seq_i      (seg_seq),
		.seg_len_i      (seg_len),
		.tx_ack_i       (tx_ack),
		.buf_ready_i    (buf_ready),
		.buf_len_i      (buf_len),
		.seg_rd_o       (seg_rd),
		.tx_req_o       (tx_req),
		.tx_flags_o     (tx_flags),
		.tx_seq_o       (tx_seq),
		.tx_ack_num_o   (tx_ack_num),
		.tx_len_o       (tx_len),
		.tx_hdr_len_o   (tx_hdr_len),
		.tx_dst_port_o  (tx_dst_port),
		.buf_sel_o      (buf_sel),
		.buf_done_o     (buf_done),
		.state_listen_o (state_listen),
		.state_estab_o  (state_estab)
	);

	tcp_checker u_checker (
		.clk            (clk),
		.rst_n          (rst_n),
		.tx_req_i       (tx_req),
		.tx_flags_i     (tx_flags),
		.tx_seq_i       (tx_seq),
		.tx_ack_num_i   (tx_ack_num),
		.tx_len_i       (tx_len),
		.tx_hdr_len_i   (tx_hdr_len),
		.tx_dst_port_i  (tx_dst_port),
		.buf_sel_i      (buf_sel),
		.buf_done_i     (buf_done),
		.state_listen_i (state_listen),
		.state_estab_i  (state_estab),
		.exp_push_i     (exp_push),
		.exp_flags_i    (exp_flags),
		.exp_seq_i      (exp_seq),
		.exp_ack_i      (exp_ack),
		.exp_len_i      (exp_len),
		.exp_dst_i      (exp_dst),
		.exp_sel_i      (exp_sel),
		.st_chk_i       (st_chk),
		.st_listen_i    (st_listen),
		.st_estab_i     (st_estab),
		.test_end_i     (test_end),
		.test_id_i      (test_id),
		.chk_cnt_o      (chk_cnt),
		.err_cnt_o      (err_cnt)
	);

	function automatic logic [31:0] rnd();
		return $random(seed);
	endfunction

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial
	begin
		while (cycles < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Run stopped: no end of test within %0d cycles", CYCLE_LIMIT);
		$display("CHECKS FAILED");
		$finish;
	end

	// ----------------------------------------
	// Transmitter with a random ack delay
	initial
	begin
		int delay;
		tx_ack = 1'b0;
		forever
		begin
			@(negedge clk);
			if (tx_req && !tx_ack)
			begin
				delay = int'(rnd() % 32'd6);
				repeat (delay) @(negedge clk);
				tx_ack = 1'b1;
				while (tx_req)
					@(negedge clk);
				tx_ack = 1'b0;
				served++;
			end
		end
	end

	// ----------------------------------------
	// Stimulus tasks, all entered on a falling edge
	task automatic expect_hdr(input logic [5:0] flags, input logic [31:0] seq,
			input logic [31:0] ack, input logic [15:0] len, input logic [3:0] sel);
		exp_flags = flags;
		exp_seq = seq;
		exp_ack = ack;
		exp_len = len;
		exp_dst = peer_port;
		exp_sel = sel;
		exp_push = 1'b1;
		expected++;
		last_ack = ack;
		@(negedge clk);
		exp_push = 1'b0;
	endtask

	task automatic send_seg(input logic [15:0] port, input logic [5:0] flags,
			input logic [31:0] seq, input logic [15:0] len);
		seg_src_port = port;
		seg_flags = flags;
		seg_seq = seq;
		seg_len = len;
		seg_valid = 1'b1;
		// Held until the latch has room
		while (!seg_rd)
			@(negedge clk);
		@(negedge clk);
		seg_valid = 1'b0;
	endtask

	task automatic wait_tx();
		while (served < expected)
			@(negedge clk);
	endtask

	task automatic check_state(input logic listen, input logic estab);
		st_listen = listen;
		st_estab = estab;
		st_chk = 1'b1;
		@(negedge clk);
		st_chk = 1'b0;
	endtask

	task automatic finish_test(input logic [3:0] id);
		repeat (2) @(negedge clk);
		test_id = id;
		test_end = 1'b1;
		@(negedge clk);
		test_end = 1'b0;
	endtask

	// SYN, SYNACK and the closing ACK from a fresh random peer
	task automatic open_connection();
		logic [31:0] isn;
		isn = rnd();
		peer_port = 16'(rnd());
		snd_nxt = tcp_pkg::ISS + 32'd1;
		expect_hdr(F_SYN | F_ACK, tcp_pkg::ISS, isn + 32'd1, 16'd0, 4'd0);
		send_seg(peer_port, F_SYN, isn, 16'd0);
		wait_tx();
		send_seg(peer_port, F_ACK, isn + 32'd1, 16'd0);
		repeat (6) @(negedge clk);
	endtask

	initial
	begin
		int k;
		int idx;
		int start;
		logic [3:0] mask;
		logic [31:0] seq;
		logic [15:0] len;
		logic [5:0] flags;
		logic done_seen;
		logic [3:0] sel_seen;
		rst_n = 1'b0;
		seg_valid = 1'b0;
		seg_src_port = '0;
		seg_flags = '0;
		seg_seq = '0;
		seg_len = '0;
		buf_ready = '0;
		buf_len = '0;
		exp_push = 1'b0;
		exp_flags = '0;
		exp_seq = '0;
		exp_ack = '0;
		exp_len = '0;
		exp_dst = '0;
		exp_sel = '0;
		st_chk = 1'b0;
		st_listen = 1'b0;
		st_estab = 1'b0;
		test_end = 1'b0;
		test_id = '0;
		peer_port = '0;
		snd_nxt = '0;
		last_ack = '0;
		last_buf = tcp_pkg::BUF_NUM - 1;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		// Handshake
		check_state(1'b1, 1'b0);
		open_connection();
		check_state(1'b0, 1'b1);
		finish_test(4'd1);

		// Data acknowledgement
		for (k = 0; k < N_DATA; k++)
		begin
			seq = rnd();
			len = 16'(rnd() % 32'd1000) + 16'd1;
			flags = seq[0] ? (F_ACK | F_PSH) : F_ACK;
			expect_hdr(F_ACK, snd_nxt, seq + {16'd0, len}, 16'd0, 4'd0);
			send_seg(peer_port, flags, seq, len);
			wait_tx();
		end
		finish_test(4'd2);

		// Foreign port is read and dropped
		send_seg(peer_port ^ 16'h8001, F_ACK, rnd(), 16'd40);
		repeat (10) @(negedge clk);
		check_state(1'b0, 1'b1);
		finish_test(4'd3);

		// ----------------------------------------
		// Buffer sending in round-robin order
		for (k = 0; k < N_ROUNDS; k++)
		begin
			mask = 4'(rnd());
			if (mask == '0)
				mask = '1;
			for (idx = 0; idx < tcp_pkg::BUF_NUM; idx++)
				blen[idx] = 16'(rnd() % 32'd1500) + 16'd1;
			start = last_buf;
			for (int i = 1; i <= tcp_pkg::BUF_NUM; i++)
			begin
				idx = (start + i) % tcp_pkg::BUF_NUM;
				if (mask[idx])
				begin
					expect_hdr(F_PSH | F_ACK, snd_nxt, last_ack, blen[idx], 4'(1 << idx));
					snd_nxt = snd_nxt + {16'd0, blen[idx]};
					last_buf = idx;
				end
			end
			for (idx = 0; idx < tcp_pkg::BUF_NUM; idx++)
				buf_len[idx*tcp_pkg::LEN_W +: tcp_pkg::LEN_W] = blen[idx];
			buf_ready = mask;
			while (buf_ready != '0)
			begin
				// Completion is seen at the rising edge
				@(posedge clk);
				done_seen = buf_done;
				sel_seen = buf_sel;
				@(negedge clk);
				// Served buffer is empty once its request completes
				if (done_seen)
					buf_ready = buf_ready & ~sel_seen;
			end
			wait_tx();
		end
		finish_test(4'd4);

		// Passive close, FIN takes one sequence number
		seq = rnd();
		len = 16'(rnd() % 32'd256);
		expect_hdr(F_ACK, snd_nxt, seq + {16'd0, len} + 32'd1, 16'd0, 4'd0);
		expect_hdr(F_FIN | F_ACK, snd_nxt, last_ack, 16'd0, 4'd0);
		send_seg(peer_port, F_FIN | F_ACK, seq, len);
		wait_tx();
		send_seg(peer_port, F_ACK, seq + {16'd0, len} + 32'd1, 16'd0);
		repeat (6) @(negedge clk);
		check_state(1'b1, 1'b0);
		finish_test(4'd5);

		// RST aborts an open connection silently
		open_connection();
		check_state(1'b0, 1'b1);
		send_seg(peer_port, F_RST, rnd(), 16'd0);
		repeat (6) @(negedge clk);
		check_state(1'b1, 1'b0);
		finish_test(4'd6);

		$display("Total: %0d checks, %0d errors", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- tb.f
common/tcp_pkg.sv
source/tcp_rx_latch.sv
tcp_ctrl/tcp_conn_fsm.sv
tcp_ctrl/tcp_tx_header.sv
source/tcp_buf_arbiter.sv
source/tcp_controller_top.sv
bench/tcp_checker.sv
bench/tb_tcp.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
	-f tb.f --top-module tb_tcp -o tb_tcp_sim
out=$(./obj_dir/tb_tcp_sim)
echo "$out"
if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1
